//--- cache_ctrl.sv
// miss handling FSM that the cache top level uses to sequence the arrays and the memory request
`timescale 1ns/1ps

module cache_ctrl (
	input  logic                        clk,
	input  logic                        proc_reset,
	input  cache_proto_pkg::proc_req_t  proc_req,
	input  logic                        hit,
	input  logic                        victim_dirty,
	input  cache_geom_pkg::way_t        hit_way,
	input  cache_geom_pkg::way_t        victim_way,
	input  cache_geom_pkg::line_addr_t  victim_line_addr,
	input  cache_geom_pkg::line_t       line_out,
	input  cache_geom_pkg::word_t       word_out,
	input  cache_proto_pkg::mem_rsp_t   mem_rsp,
	output cache_proto_pkg::proc_rsp_t  proc_rsp,
	output cache_proto_pkg::mem_req_t   mem_req,
	output logic                        store_en,
	output logic                        fill_en,
	output logic                        clean_en,
	output cache_geom_pkg::way_t        way_sel
);

	cache_proto_pkg::cache_state_t state_q;
	cache_proto_pkg::cache_state_t state_d;

	logic                       access;
	cache_geom_pkg::line_addr_t proc_line_addr;

	assign access = proc_req.read | proc_req.write;

	// drop the word offset to get the refill address
	assign proc_line_addr = proc_req.addr[$bits(cache_geom_pkg::word_addr_t)-1:
		$bits(cache_geom_pkg::word_off_t)];

	// --------------------
	// state register
	// --------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state_q <= cache_proto_pkg::st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// --------------------
	// next state
	// --------------------

	always_comb begin
		state_d = state_q;
		case (state_q)
			cache_proto_pkg::st_idle: begin
				state_d = cache_proto_pkg::st_compare;	// one cycle after reset
			end
			cache_proto_pkg::st_compare: begin
				if (access && !hit) begin
					// a dirty victim has to go out before the refill
					if (victim_dirty) begin
						state_d = cache_proto_pkg::st_write_back;
					end else begin
						state_d = cache_proto_pkg::st_allocate;
					end
				end
			end
			cache_proto_pkg::st_write_back: begin
				if (mem_rsp.ready) begin
					state_d = cache_proto_pkg::st_allocate;
				end
			end
			cache_proto_pkg::st_allocate: begin
				if (mem_rsp.ready) begin
					state_d = cache_proto_pkg::st_compare;	// hit taken next cycle
				end
			end
			default: begin
				state_d = cache_proto_pkg::st_idle;
			end
		endcase
	end

	// --------------------
	// outputs
	// --------------------

	always_comb begin
		proc_rsp.stall = 1'b1;	// idle keeps the processor waiting
		proc_rsp.rdata = word_out;
		mem_req        = '0;
		store_en       = 1'b0;
		fill_en        = 1'b0;
		clean_en       = 1'b0;
		way_sel        = hit_way;

		case (state_q)
			cache_proto_pkg::st_compare: begin
				if (!access || hit) begin
					proc_rsp.stall = 1'b0;
				end
				store_en = proc_req.write & hit;	// word lands at the next edge
			end
			cache_proto_pkg::st_write_back: begin
				way_sel        = victim_way;
				mem_req.write  = 1'b1;
				mem_req.addr   = victim_line_addr;
				mem_req.wdata  = line_out;
				clean_en       = mem_rsp.ready;
			end
			cache_proto_pkg::st_allocate: begin
				way_sel        = victim_way;
				mem_req.read   = 1'b1;
				mem_req.addr   = proc_line_addr;
				fill_en        = mem_rsp.ready;	// refill the victim way
			end
		endcase
	end

endmodule

//--- cache_data_array.sv
// line storage of the cache, word read by offset, word merge on store and line fill on refill
`timescale 1ns/1ps

module cache_data_array #(
	parameter int set_bits = 2
) (
	input  logic                        clk,
	input  cache_geom_pkg::word_addr_t  addr,
	input  cache_geom_pkg::way_t        way_sel,
	input  logic                        store_en,
	input  logic                        fill_en,
	input  cache_geom_pkg::word_t       store_word,
	input  cache_geom_pkg::line_t       fill_line,
	output cache_geom_pkg::line_t       line_out,
	output cache_geom_pkg::word_t       word_out
);

	localparam int num_sets = 1 << set_bits;
	localparam int off_bits = $bits(cache_geom_pkg::word_off_t);

	typedef logic [set_bits-1:0] set_t;

	// a line seen as its words, word 0 lowest
	typedef cache_geom_pkg::word_t [cache_geom_pkg::words_per_line-1:0] line_words_t;

	cache_geom_pkg::line_t data_q [num_sets][cache_geom_pkg::num_ways];

	set_t                      set_idx;
	cache_geom_pkg::word_off_t word_off;
	line_words_t               rd_words;
	line_words_t               merged;

	assign set_idx  = addr[off_bits +: set_bits];
	assign word_off = addr[off_bits-1:0];

	// --------------------
	// read side
	// --------------------

	assign line_out = data_q[set_idx][way_sel];
	assign rd_words = line_out;
	assign word_out = rd_words[word_off];

	// store touches one word, rest of the line kept
	always_comb begin
		merged           = rd_words;
		merged[word_off] = store_word;
	end

	// --------------------
	// write side
	// --------------------

	always_ff @(posedge clk) begin
		if (fill_en) begin
			data_q[set_idx][way_sel] <= fill_line;	// whole line from memory
		end else if (store_en) begin
			data_q[set_idx][way_sel] <= merged;
		end
	end

endmodule

//--- cache_geom_pkg.sv
// address and data geometry shared by the cache blocks, pulled in by scoped names
package cache_geom_pkg;

	// --------------------
	// word and line sizes
	// --------------------

	// one processor data word
	typedef logic [31:0] word_t;

	// one memory line, word 0 in the low bits
	typedef logic [127:0] line_t;

	localparam int unsigned words_per_line = 4;

	// index of a word inside its line
	typedef logic [1:0] word_off_t;

	// --------------------
	// addresses
	// --------------------

	// word address from the processor, byte offset already stripped
	typedef logic [29:0] word_addr_t;

	// line address toward memory = word address without the word offset
	typedef logic [27:0] line_addr_t;

	// --------------------
	// associativity
	// --------------------

	localparam int unsigned num_ways = 2;

	// selects one of the two ways
	typedef logic [0:0] way_t;

endpackage

//--- cache_proto_pkg.sv
// port bundles and controller states of the cache, pulled in by scoped names
package cache_proto_pkg;

	// --------------------
	// processor side
	// --------------------

	// held steady by the processor until stall drops
	typedef struct packed {
		logic                       read;
		logic                       write;
		cache_geom_pkg::word_addr_t addr;
		cache_geom_pkg::word_t      wdata;
	} proc_req_t;

	typedef struct packed {
		logic                  stall;	// high while a miss is in flight
		cache_geom_pkg::word_t rdata;	// valid on a read hit
	} proc_rsp_t;

	// --------------------
	// memory side
	// --------------------

	// read or write level, held until ready
	typedef struct packed {
		logic                       read;
		logic                       write;
		cache_geom_pkg::line_addr_t addr;
		cache_geom_pkg::line_t      wdata;
	} mem_req_t;

	typedef struct packed {
		cache_geom_pkg::line_t rdata;
		logic                  ready;	// one cycle, ends the request
	} mem_rsp_t;

	// miss handling states
	typedef enum logic [1:0] {
		st_idle,
		st_compare,
		st_write_back,
		st_allocate
	} cache_state_t;

endpackage

//--- cache_tag_array.sv
// valid, dirty, tag and replacement bits of the cache, with hit and victim lookup per set
`timescale 1ns/1ps

module cache_tag_array #(
	parameter int set_bits = 2
) (
	input  logic                        clk,
	input  logic                        proc_reset,
	input  cache_geom_pkg::word_addr_t  addr,
	input  logic                        store_en,
	input  logic                        fill_en,
	input  logic                        clean_en,
	input  cache_geom_pkg::way_t        way_sel,
	output logic                        hit,
	output logic                        victim_dirty,
	output cache_geom_pkg::way_t        hit_way,
	output cache_geom_pkg::way_t        victim_way,
	output cache_geom_pkg::line_addr_t  victim_line_addr
);

	localparam int num_sets = 1 << set_bits;
	localparam int off_bits = $bits(cache_geom_pkg::word_off_t);
	localparam int tag_bits = $bits(cache_geom_pkg::line_addr_t) - set_bits;

	typedef logic [set_bits-1:0] set_t;
	typedef logic [tag_bits-1:0] tag_t;

	logic [num_sets-1:0][cache_geom_pkg::num_ways-1:0] valid_q;
	logic [num_sets-1:0][cache_geom_pkg::num_ways-1:0] dirty_q;
	logic [num_sets-1:0]                               repl_q;	// way to evict next
	tag_t tag_q [num_sets][cache_geom_pkg::num_ways];

	set_t                                set_idx;
	tag_t                                addr_tag;
	logic [cache_geom_pkg::num_ways-1:0] match;

	assign set_idx  = addr[off_bits +: set_bits];
	assign addr_tag = addr[$bits(cache_geom_pkg::word_addr_t)-1 -: tag_bits];

	// --------------------
	// lookup
	// --------------------

	always_comb begin
		for (int w = 0; w < cache_geom_pkg::num_ways; w++) begin
			match[w] = valid_q[set_idx][w] && (tag_q[set_idx][w] == addr_tag);
		end
	end

	assign hit     = |match;
	assign hit_way = cache_geom_pkg::way_t'(match[1]);

	assign victim_way       = repl_q[set_idx];
	assign victim_dirty     = valid_q[set_idx][victim_way] & dirty_q[set_idx][victim_way];
	assign victim_line_addr = {tag_q[set_idx][victim_way], set_idx};	// address of the evicted line

	// --------------------
	// state bits
	// --------------------

	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid_q <= '0;
			dirty_q <= '0;
			repl_q  <= '0;
		end else begin
			if (fill_en) begin
				valid_q[set_idx][way_sel] <= 1'b1;
				dirty_q[set_idx][way_sel] <= 1'b0;
				repl_q[set_idx]           <= ~repl_q[set_idx];	// only a refill moves it
			end else if (store_en) begin
				dirty_q[set_idx][way_sel] <= 1'b1;
			end else if (clean_en) begin
				dirty_q[set_idx][way_sel] <= 1'b0;	// line is back in memory
			end
		end
	end

	// tag of the refilled line
	always_ff @(posedge clk) begin
		if (fill_en) begin
			tag_q[set_idx][way_sel] <= addr_tag;
		end
	end

endmodule

//--- cache_top.sv
// two-way write-back cache, word port to the processor and line port to slow memory
`timescale 1ns/1ps

module cache_top #(
	parameter int set_bits = 2	// log2 of the set count
) (
	input  logic                        clk,
	input  logic                        proc_reset,
	input  cache_proto_pkg::proc_req_t  proc_req,
	output cache_proto_pkg::proc_rsp_t  proc_rsp,
	output cache_proto_pkg::mem_req_t   mem_req,
	input  cache_proto_pkg::mem_rsp_t   mem_rsp
);

	// lookup results
	logic                       hit;
	logic                       victim_dirty;
	cache_geom_pkg::way_t       hit_way;
	cache_geom_pkg::way_t       victim_way;
	cache_geom_pkg::line_addr_t victim_line_addr;

	// array commands
	logic                       store_en;
	logic                       fill_en;
	logic                       clean_en;
	cache_geom_pkg::way_t       way_sel;

	// array read data
	cache_geom_pkg::line_t      line_out;
	cache_geom_pkg::word_t      word_out;

	cache_ctrl ctrl_i (
		.clk              (clk),
		.proc_reset       (proc_reset),
		.proc_req         (proc_req),
		.hit              (hit),
		.victim_dirty     (victim_dirty),
		.hit_way          (hit_way),
		.victim_way       (victim_way),
		.victim_line_addr (victim_line_addr),
		.line_out         (line_out),
		.word_out         (word_out),
		.mem_rsp          (mem_rsp),
		.proc_rsp         (proc_rsp),
		.mem_req          (mem_req),
		.store_en         (store_en),
		.fill_en          (fill_en),
		.clean_en         (clean_en),
		.way_sel          (way_sel)
	);

	cache_tag_array #(.set_bits(set_bits)) tag_i (
		.clk              (clk),
		.proc_reset       (proc_reset),
		.addr             (proc_req.addr),
		.store_en         (store_en),
		.fill_en          (fill_en),
		.clean_en         (clean_en),
		.way_sel          (way_sel),
		.hit              (hit),
		.victim_dirty     (victim_dirty),
		.hit_way          (hit_way),
		.victim_way       (victim_way),
		.victim_line_addr (victim_line_addr)
	);

	cache_data_array #(.set_bits(set_bits)) data_i (
		.clk        (clk),
		.addr       (proc_req.addr),
		.way_sel    (way_sel),
		.store_en   (store_en),
		.fill_en    (fill_en),
		.store_word (proc_req.wdata),
		.fill_line  (mem_rsp.rdata),	// refill data straight from memory
		.line_out   (line_out),
		.word_out   (word_out)
	);

endmodule

//--- sources.f
cache_geom_pkg.sv
cache_proto_pkg.sv
cache_tag_array.sv
cache_data_array.sv
cache_ctrl.sv
cache_top.sv
tb_clk_gen.sv
tb_slow_mem.sv
tb_cache.sv

//--- tb_cache.sv
// testbench top for the cache, random and directed traffic checked against a shadow memory
`timescale 1ns/1ps

module tb_cache;

	localparam int num_random = 300;
	localparam int max_cycles = 200 * (2 * num_random + 8);	// 200 cycles per transaction

	localparam cache_geom_pkg::line_addr_t line_a = 28'd64;	// all three in set 0
	localparam cache_geom_pkg::line_addr_t line_b = 28'd128;
	localparam cache_geom_pkg::line_addr_t line_c = 28'd192;

	logic                       clk;
	logic                       proc_reset;
	cache_proto_pkg::proc_req_t proc_req;
	cache_proto_pkg::proc_rsp_t proc_rsp;
	cache_proto_pkg::mem_req_t  mem_req;
	cache_proto_pkg::mem_rsp_t  mem_rsp;
	int                         wb_count;
	cache_geom_pkg::line_addr_t wb_addr;
	cache_geom_pkg::line_t      wb_data;

	cache_geom_pkg::word_t shadow_mem [4096];
	bit                    written [4096];
	logic [31:0]           rnd_state;
	int word_errors  = 0;
	int line_errors  = 0;
	int addr_errors  = 0;
	int flag_errors  = 0;
	int other_errors = 0;

	tb_clk_gen clk_i (.clk(clk), .proc_reset(proc_reset));

	cache_top #(.set_bits(2)) dut_i (
		.clk(clk), .proc_reset(proc_reset), .proc_req(proc_req),
		.proc_rsp(proc_rsp), .mem_req(mem_req), .mem_rsp(mem_rsp)
	);

	tb_slow_mem #(.num_lines(1024), .seed(32'd30890)) mem_i (
		.clk(clk), .mem_req(mem_req), .mem_rsp(mem_rsp),
		.wb_count(wb_count), .wb_addr(wb_addr), .wb_data(wb_data)
	);

	// --------------------
	// reference model
	// --------------------

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic cache_geom_pkg::word_t init_word(input cache_geom_pkg::word_addr_t a);
		return ({2'b00, a} * 32'h0001_0003) ^ 32'h9e37_79b9;
	endfunction

	// last value written, else what memory held at start
	function automatic cache_geom_pkg::word_t expected_word(input cache_geom_pkg::word_addr_t a);
		if (written[a[11:0]]) return shadow_mem[a[11:0]];
		return init_word(a);
	endfunction

	function automatic cache_geom_pkg::line_t expected_line(input cache_geom_pkg::line_addr_t la);
		cache_geom_pkg::line_t l;
		for (int w = 0; w < cache_geom_pkg::words_per_line; w++) begin
			l[w*32 +: 32] = expected_word({la, cache_geom_pkg::word_off_t'(w)});
		end
		return l;
	endfunction

	task automatic record_write(input cache_geom_pkg::word_addr_t a, input cache_geom_pkg::word_t d);
		shadow_mem[a[11:0]] = d;
		written[a[11:0]]    = 1'b1;
	endtask

	// --------------------
	// compare tasks
	// --------------------

	task automatic check_word(input cache_geom_pkg::word_t got, exp, input string what);
		if (got !== exp) begin
			word_errors++;
			$display("ERROR at %0t: %s got %08h expected %08h", $time, what, got, exp);
		end
	endtask

	task automatic check_line(input cache_geom_pkg::line_t got, exp, input string what);
		if (got !== exp) begin
			line_errors++;
			$display("ERROR at %0t: %s got %032h expected %032h", $time, what, got, exp);
		end
	endtask

	task automatic check_addr(input cache_geom_pkg::line_addr_t got, exp, input string what);
		if (got !== exp) begin
			addr_errors++;
			$display("ERROR at %0t: %s got %07h expected %07h", $time, what, got, exp);
		end
	endtask

	task automatic check_flag(input logic got, exp, input string what);
		if (got !== exp) begin
			flag_errors++;
			$display("ERROR at %0t: %s got %b expected %b", $time, what, got, exp);
		end
	endtask

	// monitor, everything sampled at the falling edge
	initial begin : compare
		cache_proto_pkg::mem_req_t prev_req;
		logic                      prev_waiting;
		prev_req     = '0;
		prev_waiting = 1'b0;
		@(negedge proc_reset);
		@(negedge clk);
		check_flag(proc_rsp.stall, 1'b1, "stall in first cycle after reset");
		check_flag(mem_req.read, 1'b0, "mem read in first cycle after reset");
		check_flag(mem_req.write, 1'b0, "mem write in first cycle after reset");
		forever begin
			@(negedge clk);
			if (prev_waiting) begin	// no ready at the last edge, request must hold
				check_flag(mem_req.read, prev_req.read, "mem read under back-pressure");
				check_flag(mem_req.write, prev_req.write, "mem write under back-pressure");
				check_addr(mem_req.addr, prev_req.addr, "mem addr under back-pressure");
				check_line(mem_req.wdata, prev_req.wdata, "mem wdata under back-pressure");
				check_flag(proc_rsp.stall, 1'b1, "stall under back-pressure");
			end
			if (!proc_rsp.stall && proc_req.read)
				check_word(proc_rsp.rdata, expected_word(proc_req.addr), "read data");
			if (!proc_rsp.stall && proc_req.write)
				record_write(proc_req.addr, proc_req.wdata);
			prev_req     = mem_req;
			prev_waiting = (mem_req.read || mem_req.write) && !mem_rsp.ready;
		end
	end

	// --------------------
	// stimulus
	// --------------------

	task automatic run_access(input logic is_write, input cache_geom_pkg::word_addr_t a,
			input cache_geom_pkg::word_t d, output int cycles);
		@(posedge clk);
		#1;
		proc_req.read  = !is_write;
		proc_req.write = is_write;
		proc_req.addr  = a;
		proc_req.wdata = d;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (proc_rsp.stall);
	endtask

	// another word of the line just refilled, has to hit at once
	task automatic reread_line(input cache_geom_pkg::word_addr_t a);
		int cycles;
		run_access(1'b0, {a[29:2], a[1:0] + 2'd1}, '0, cycles);
		if (cycles != 1) begin
			other_errors++;
			$display("repeated access to line %07h stalled for %0d cycles after its refill",
				a[29:2], cycles);
		end
	endtask

	initial begin : stimulus
		int                         cycles;
		int                         wb_before;
		logic                       is_write;
		cache_geom_pkg::word_addr_t a;
		proc_req  = '0;
		rnd_state = 32'd30890;
		@(negedge proc_reset);
		// random traffic over lines 0 to 15
		for (int i = 0; i < num_random; i++) begin
			rnd_state = lcg_next(rnd_state);
			is_write  = rnd_state[20];
			a         = cache_geom_pkg::word_addr_t'(rnd_state[29:24]);
			rnd_state = lcg_next(rnd_state);
			run_access(is_write, a, rnd_state, cycles);
			if (cycles > 1) reread_line(a);
		end
		// three dirty lines in one set, the third evicts the first
		run_access(1'b1, {line_a, 2'd1}, 32'hdead_0001, cycles);
		run_access(1'b1, {line_b, 2'd2}, 32'hdead_0002, cycles);
		wb_before = wb_count;
		run_access(1'b1, {line_c, 2'd0}, 32'hdead_0003, cycles);
		if (wb_count != wb_before + 1) begin
			other_errors++;
			$display("eviction in set 0 gave %0d write-backs instead of one", wb_count - wb_before);
		end
		check_addr(wb_addr, line_a, "write-back address");
		check_line(wb_data, expected_line(line_a), "write-back data");
		@(posedge clk);
		#1;
		proc_req = '0;
		repeat (4) @(posedge clk);
		$display("errors: word %0d, line %0d, addr %0d, flag %0d, other %0d",
			word_errors, line_errors, addr_errors, flag_errors, other_errors);
		if (word_errors + line_errors + addr_errors + flag_errors + other_errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		repeat (max_cycles) @(posedge clk);
		$display("the cache did not finish the traffic within %0d clock cycles and seems hung",
			max_cycles);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

//--- tb_clk_gen.sv
// testbench clock and reset source, 8 ns clock with reset held for the first 4 cycles
`timescale 1ns/1ps

module tb_clk_gen #(
	parameter int half_period  = 4,
	parameter int reset_cycles = 4
) (
	output logic clk,
	output logic proc_reset
);

	initial begin
		clk = 1'b0;
		forever #(half_period) clk = ~clk;
	end

	// released just after a rising edge
	initial begin
		proc_reset = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#1;
		proc_reset = 1'b0;
	end

endmodule

//--- tb_slow_mem.sv
// testbench line memory with a random ready delay, keeps the last write-back for the checks
`timescale 1ns/1ps

module tb_slow_mem #(
	parameter int          num_lines = 1024,
	parameter logic [31:0] seed      = 32'd30890
) (
	input  logic                       clk,
	input  cache_proto_pkg::mem_req_t  mem_req,
	output cache_proto_pkg::mem_rsp_t  mem_rsp,
	output int                         wb_count,
	output cache_geom_pkg::line_addr_t wb_addr,
	output cache_geom_pkg::line_t      wb_data
);

	cache_geom_pkg::line_t lines [num_lines];
	logic [31:0]           rnd_state;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// start-up contents, every address bit counts
	function automatic cache_geom_pkg::word_t init_word(input cache_geom_pkg::word_addr_t a);
		return ({2'b00, a} * 32'h0001_0003) ^ 32'h9e37_79b9;
	endfunction

	initial begin : serve
		cache_proto_pkg::mem_req_t held;
		int                        delay;
		int                        idx;
		rnd_state = seed;
		mem_rsp   = '0;
		wb_count  = 0;
		wb_addr   = '0;
		wb_data   = '0;
		for (int l = 0; l < num_lines; l++) begin
			for (int w = 0; w < cache_geom_pkg::words_per_line; w++) begin
				lines[l][w*32 +: 32] = init_word(cache_geom_pkg::word_addr_t'(l * 4 + w));
			end
		end
		forever begin
			@(negedge clk);	// request is settled mid-cycle
			if (mem_req.read || mem_req.write) begin
				held      = mem_req;
				idx       = int'(held.addr) % num_lines;
				rnd_state = lcg_next(rnd_state);
				delay     = 1 + int'(rnd_state[30:16] % 6);
				repeat (delay - 1) @(negedge clk);	// ready withheld
				@(posedge clk);
				#1;
				if (held.write) begin
					lines[idx] = held.wdata;
					wb_count++;
					wb_addr = held.addr;
					wb_data = held.wdata;
				end
				mem_rsp.rdata = lines[idx];
				mem_rsp.ready = 1'b1;
				@(posedge clk);
				#1;
				mem_rsp.ready = 1'b0;
			end
		end
	end

endmodule
